//--- hw/cpu_pkg.sv
package cpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0]       PC_RESET_ADDR = 32'h0000_0000;
    localparam logic [XLEN-1:0]       ZERO_WORD     = 32'h0000_0000;
    localparam logic [REG_ADDR_W-1:0] REG_ZERO      = 5'd0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ADDIU maps to OP_ADDU, ORI to OP_OR
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_SLT,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE
    } oper_e;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        ADDIU   = 6'h09,
        ORI     = 6'h0d,
        LUI     = 6'h0f,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_e;

endpackage

//--- hw/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;

    logic                     req;
    logic                     we;
    logic [cpu_pkg::XLEN-1:0] addr;
    logic [cpu_pkg::XLEN-1:0] wdata;
    logic [cpu_pkg::XLEN-1:0] rdata;
    logic                     gnt;

    // requester side
    modport master (output req, we, addr, wdata, input rdata, gnt);

    // arbiter side
    modport slave (input req, we, addr, wdata, output rdata, gnt);

endinterface

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     hold_i,
    input  logic                     branch_flag_i,
    input  logic [cpu_pkg::XLEN-1:0] branch_target_i,
    mem_port_if.master               imem,
    output logic [cpu_pkg::XLEN-1:0] inst_o,
    output logic [cpu_pkg::XLEN-1:0] pc_o
);

    logic [cpu_pkg::XLEN-1:0] pc_q;
    logic [cpu_pkg::XLEN-1:0] next_pc;
    logic [cpu_pkg::XLEN-1:0] pend_target_q;
    logic                     pend_q;
    logic                     advance;

    assign imem.req   = 1'b1;
    assign imem.we    = 1'b0;
    assign imem.addr  = pc_q;
    assign imem.wdata = cpu_pkg::ZERO_WORD;

    assign advance = imem.gnt && !hold_i;

    // a redirect seen while the port was busy waits for the delay slot fetch
    assign next_pc = branch_flag_i ? branch_target_i :
                     pend_q        ? pend_target_q   : pc_q + 32'd4;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q   <= cpu_pkg::PC_RESET_ADDR;
            inst_o <= cpu_pkg::ZERO_WORD;
            pend_q <= 1'b0;
        end else if (advance) begin
            pc_q   <= next_pc;
            inst_o <= imem.rdata;
            pend_q <= 1'b0;
        end else begin
            // bubble on a lost grant, keep the word on a load-use hold
            if (!hold_i) begin
                inst_o <= cpu_pkg::ZERO_WORD;
            end
            if (branch_flag_i) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            pc_o <= pc_q;
        end
        if (branch_flag_i && !advance) begin
            pend_target_q <= branch_target_i;
        end
    end

endmodule

//--- hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic [cpu_pkg::XLEN-1:0]       pc_i,
    input  logic [cpu_pkg::XLEN-1:0]       inst_i,

    output logic [cpu_pkg::REG_ADDR_W-1:0] reg1_addr_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] reg2_addr_o,
    input  logic [cpu_pkg::XLEN-1:0]       reg1_data_i,
    input  logic [cpu_pkg::XLEN-1:0]       reg2_data_i,

    // forwarding from execute and memory
    input  logic                           ex_wreg_write_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_wreg_addr_i,
    input  logic [cpu_pkg::XLEN-1:0]       ex_wreg_data_i,
    input  logic                           ex_is_load_i,
    input  logic                           mem_wreg_write_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] mem_wreg_addr_i,
    input  logic [cpu_pkg::XLEN-1:0]       mem_wreg_data_i,

    output cpu_pkg::oper_e                 oper_o,
    output logic [cpu_pkg::XLEN-1:0]       reg1_o,
    output logic [cpu_pkg::XLEN-1:0]       reg2_o,
    output logic                           wreg_write_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wreg_addr_o,
    output logic                           branch_flag_o,
    output logic [cpu_pkg::XLEN-1:0]       branch_target_o,
    output logic                           load_use_stall_o
);

    cpu_pkg::opcode_e               opcode;
    cpu_pkg::funct_e                funct;
    cpu_pkg::oper_e                 oper;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs;
    logic [cpu_pkg::REG_ADDR_W-1:0] rt;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd;
    logic [cpu_pkg::REG_ADDR_W-1:0] wreg_addr;
    logic [cpu_pkg::XLEN-1:0]       imm;
    logic [cpu_pkg::XLEN-1:0]       op1_raw;
    logic [cpu_pkg::XLEN-1:0]       op1;
    logic [cpu_pkg::XLEN-1:0]       op2;
    logic                           reg1_read;
    logic                           reg2_read;
    logic                           wreg_write;
    logic                           taken;

    assign opcode = cpu_pkg::opcode_e'(inst_i[31:26]);
    assign funct  = cpu_pkg::funct_e'(inst_i[5:0]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        oper       = cpu_pkg::OP_NOP;
        reg1_read  = 1'b0;
        reg2_read  = 1'b0;
        wreg_write = 1'b0;
        wreg_addr  = rt;
        imm        = {{16{inst_i[15]}}, inst_i[15:0]};
        case (opcode)
            cpu_pkg::SPECIAL: begin
                case (funct)
                    cpu_pkg::ADDU: oper = cpu_pkg::OP_ADDU;
                    cpu_pkg::SUBU: oper = cpu_pkg::OP_SUBU;
                    cpu_pkg::AND:  oper = cpu_pkg::OP_AND;
                    cpu_pkg::OR:   oper = cpu_pkg::OP_OR;
                    cpu_pkg::SLT:  oper = cpu_pkg::OP_SLT;
                    default:       oper = cpu_pkg::OP_NOP;
                endcase
                reg1_read  = (oper != cpu_pkg::OP_NOP);
                reg2_read  = (oper != cpu_pkg::OP_NOP);
                wreg_write = (oper != cpu_pkg::OP_NOP);
                wreg_addr  = rd;
            end
            cpu_pkg::ADDIU: begin
                oper       = cpu_pkg::OP_ADDU;
                reg1_read  = 1'b1;
                wreg_write = 1'b1;
            end
            cpu_pkg::ORI: begin
                oper       = cpu_pkg::OP_OR;
                reg1_read  = 1'b1;
                wreg_write = 1'b1;
                imm        = {16'h0000, inst_i[15:0]};
            end
            cpu_pkg::LUI: begin
                oper       = cpu_pkg::OP_LUI;
                wreg_write = 1'b1;
                imm        = {16'h0000, inst_i[15:0]};
            end
            cpu_pkg::LW: begin
                oper       = cpu_pkg::OP_LW;
                reg1_read  = 1'b1;
                wreg_write = 1'b1;
            end
            cpu_pkg::SW: begin
                oper      = cpu_pkg::OP_SW;
                reg1_read = 1'b1;
                reg2_read = 1'b1;
            end
            cpu_pkg::BEQ, cpu_pkg::BNE: begin
                oper      = (opcode == cpu_pkg::BEQ) ? cpu_pkg::OP_BEQ : cpu_pkg::OP_BNE;
                reg1_read = 1'b1;
                reg2_read = 1'b1;
            end
            default: oper = cpu_pkg::OP_NOP;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operands, forwarding priority ex > mem > regfile
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [cpu_pkg::XLEN-1:0] pick_operand(
        input logic                           rd_en,
        input logic [cpu_pkg::REG_ADDR_W-1:0] addr,
        input logic [cpu_pkg::XLEN-1:0]       rf_data,
        input logic [cpu_pkg::XLEN-1:0]       imm_val
    );
        if (!rd_en) begin
            return imm_val;
        end
        if (addr == cpu_pkg::REG_ZERO) begin
            return cpu_pkg::ZERO_WORD;
        end
        if (ex_wreg_write_i && ex_wreg_addr_i == addr) begin
            return ex_wreg_data_i;
        end
        if (mem_wreg_write_i && mem_wreg_addr_i == addr) begin
            return mem_wreg_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        op1_raw = pick_operand(reg1_read, rs, reg1_data_i, imm);
        op2     = pick_operand(reg2_read, rt, reg2_data_i, imm);
    end

    // base plus offset for memory ops
    assign op1 = (oper == cpu_pkg::OP_LW || oper == cpu_pkg::OP_SW) ? op1_raw + imm : op1_raw;

    // load in execute feeding a source here
    assign load_use_stall_o = ex_is_load_i && ex_wreg_write_i &&
                              ex_wreg_addr_i != cpu_pkg::REG_ZERO &&
                              ((reg1_read && ex_wreg_addr_i == rs) ||
                               (reg2_read && ex_wreg_addr_i == rt));

    // branch resolution, target relative to the delay slot
    assign taken = (oper == cpu_pkg::OP_BEQ && op1_raw == op2) ||
                   (oper == cpu_pkg::OP_BNE && op1_raw != op2);
    assign branch_flag_o   = taken && !load_use_stall_o;
    assign branch_target_o = pc_i + 32'd4 + {imm[29:0], 2'b00};

    // decode/execute register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            oper_o       <= cpu_pkg::OP_NOP;
            wreg_write_o <= 1'b0;
        end else if (load_use_stall_o) begin
            oper_o       <= cpu_pkg::OP_NOP;
            wreg_write_o <= 1'b0;
        end else begin
            oper_o       <= oper;
            wreg_write_o <= wreg_write;
        end
    end

    always_ff @(posedge clk_i) begin
        reg1_o      <= op1;
        reg2_o      <= op2;
        wreg_addr_o <= wreg_addr;
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2_i,
    input  logic                           we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [cpu_pkg::XLEN-1:0]       wdata_i,
    output logic [cpu_pkg::XLEN-1:0]       rdata1_o,
    output logic [cpu_pkg::XLEN-1:0]       rdata2_o
);

    // r0 has no storage
    logic [cpu_pkg::XLEN-1:0] regs [1:31];

    function automatic logic [cpu_pkg::XLEN-1:0] read_port(
        input logic [cpu_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == cpu_pkg::REG_ZERO) begin
            return cpu_pkg::ZERO_WORD;
        end
        // write-through to a read in the same cycle
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= cpu_pkg::ZERO_WORD;
            end
        end else if (we_i && waddr_i != cpu_pkg::REG_ZERO) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  cpu_pkg::oper_e                 oper_i,
    input  logic [cpu_pkg::XLEN-1:0]       reg1_i,
    input  logic [cpu_pkg::XLEN-1:0]       reg2_i,
    input  logic                           wreg_write_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wreg_addr_i,

    output cpu_pkg::oper_e                 oper_o,
    output logic [cpu_pkg::XLEN-1:0]       result_o,
    output logic [cpu_pkg::XLEN-1:0]       store_data_o,
    output logic                           wreg_write_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wreg_addr_o,

    // forwarding back to decode
    output logic [cpu_pkg::XLEN-1:0]       wreg_data_o,
    output logic                           is_load_o
);

    logic [cpu_pkg::XLEN-1:0] result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (oper_i)
            cpu_pkg::OP_ADDU: result = reg1_i + reg2_i;
            cpu_pkg::OP_SUBU: result = reg1_i - reg2_i;
            cpu_pkg::OP_AND:  result = reg1_i & reg2_i;
            cpu_pkg::OP_OR:   result = reg1_i | reg2_i;
            cpu_pkg::OP_SLT:  result = {31'd0, $signed(reg1_i) < $signed(reg2_i)};
            cpu_pkg::OP_LUI:  result = {reg2_i[15:0], 16'h0000};
            // address already folded in decode
            cpu_pkg::OP_LW,
            cpu_pkg::OP_SW:   result = reg1_i;
            default:          result = cpu_pkg::ZERO_WORD;
        endcase
    end

    assign wreg_data_o = result;
    assign is_load_o   = (oper_i == cpu_pkg::OP_LW);

    // execute/memory register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            oper_o       <= cpu_pkg::OP_NOP;
            wreg_write_o <= 1'b0;
        end else begin
            oper_o       <= oper_i;
            wreg_write_o <= wreg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_o     <= result;
        store_data_o <= reg2_i;
        wreg_addr_o  <= wreg_addr_i;
    end

endmodule

//--- hw/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  cpu_pkg::oper_e                 oper_i,
    input  logic [cpu_pkg::XLEN-1:0]       result_i,
    input  logic [cpu_pkg::XLEN-1:0]       store_data_i,
    input  logic                           wreg_write_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wreg_addr_i,
    mem_port_if.master                     dmem,
    output logic                           wb_write_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [cpu_pkg::XLEN-1:0]       wb_data_o,
    output logic [cpu_pkg::XLEN-1:0]       mem_wreg_data_o
);

    logic is_load;
    logic is_store;

    assign is_load  = (oper_i == cpu_pkg::OP_LW);
    assign is_store = (oper_i == cpu_pkg::OP_SW);

    assign dmem.req   = is_load || is_store;
    assign dmem.we    = is_store;
    assign dmem.addr  = result_i;
    assign dmem.wdata = store_data_i;

    // memory answers in the same cycle
    assign mem_wreg_data_o = (is_load && dmem.gnt) ? dmem.rdata : result_i;

    // memory/write-back register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_write_o <= 1'b0;
        end else begin
            wb_write_o <= wreg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= wreg_addr_i;
        wb_data_o <= mem_wreg_data_o;
    end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    mem_port_if.slave                imem,
    mem_port_if.slave                dmem,
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output logic [cpu_pkg::XLEN-1:0] mem_addr_o,
    output logic [cpu_pkg::XLEN-1:0] mem_wdata_o,
    input  logic [cpu_pkg::XLEN-1:0] mem_rdata_i
);

    // data port owned the memory last cycle
    logic data_owner_q;

    // fixed priority, data first
    assign dmem.gnt = dmem.req;
    assign imem.gnt = imem.req && !dmem.req;

    assign mem_req_o  = imem.req || dmem.req;
    assign mem_we_o   = dmem.req && dmem.we;
    assign mem_addr_o = dmem.req ? dmem.addr : imem.addr;

    // write data stays on the data side for a cycle after a data access
    assign mem_wdata_o = (dmem.req || data_owner_q) ? dmem.wdata : cpu_pkg::ZERO_WORD;

    assign imem.rdata = mem_rdata_i;
    assign dmem.rdata = mem_rdata_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_owner_q <= 1'b0;
        end else begin
            data_owner_q <= dmem.gnt;
        end
    end

endmodule

//--- hw/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output logic [cpu_pkg::XLEN-1:0] mem_addr_o,
    output logic [cpu_pkg::XLEN-1:0] mem_wdata_o,
    input  logic [cpu_pkg::XLEN-1:0] mem_rdata_i
);

    // fetch/decode
    logic [cpu_pkg::XLEN-1:0]       if_inst;
    logic [cpu_pkg::XLEN-1:0]       if_pc;
    logic                           branch_flag;
    logic [cpu_pkg::XLEN-1:0]       branch_target;
    logic                           load_use_stall;

    // regfile
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr1;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr2;
    logic [cpu_pkg::XLEN-1:0]       rf_rdata1;
    logic [cpu_pkg::XLEN-1:0]       rf_rdata2;

    // decode/execute
    cpu_pkg::oper_e                 id_oper;
    logic [cpu_pkg::XLEN-1:0]       id_reg1;
    logic [cpu_pkg::XLEN-1:0]       id_reg2;
    logic                           id_wreg_write;
    logic [cpu_pkg::REG_ADDR_W-1:0] id_wreg_addr;

    // execute/memory
    cpu_pkg::oper_e                 ex_oper;
    logic [cpu_pkg::XLEN-1:0]       ex_result;
    logic [cpu_pkg::XLEN-1:0]       ex_store_data;
    logic                           ex_wreg_write;
    logic [cpu_pkg::REG_ADDR_W-1:0] ex_wreg_addr;
    logic [cpu_pkg::XLEN-1:0]       ex_fwd_data;
    logic                           ex_is_load;

    // memory/write-back
    logic                           wb_write;
    logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr;
    logic [cpu_pkg::XLEN-1:0]       wb_data;
    logic [cpu_pkg::XLEN-1:0]       mem_fwd_data;

    mem_port_if imem_if ();
    mem_port_if dmem_if ();

    fetch_unit u_fetch_unit (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .hold_i          (load_use_stall),
        .branch_flag_i   (branch_flag),
        .branch_target_i (branch_target),
        .imem            (imem_if.master),
        .inst_o          (if_inst),
        .pc_o            (if_pc)
    );

    id_stage u_id_stage (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .pc_i             (if_pc),
        .inst_i           (if_inst),
        .reg1_addr_o      (rf_raddr1),
        .reg2_addr_o      (rf_raddr2),
        .reg1_data_i      (rf_rdata1),
        .reg2_data_i      (rf_rdata2),
        .ex_wreg_write_i  (id_wreg_write),
        .ex_wreg_addr_i   (id_wreg_addr),
        .ex_wreg_data_i   (ex_fwd_data),
        .ex_is_load_i     (ex_is_load),
        .mem_wreg_write_i (ex_wreg_write),
        .mem_wreg_addr_i  (ex_wreg_addr),
        .mem_wreg_data_i  (mem_fwd_data),
        .oper_o           (id_oper),
        .reg1_o           (id_reg1),
        .reg2_o           (id_reg2),
        .wreg_write_o     (id_wreg_write),
        .wreg_addr_o      (id_wreg_addr),
        .branch_flag_o    (branch_flag),
        .branch_target_o  (branch_target),
        .load_use_stall_o (load_use_stall)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .we_i     (wb_write),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    execute_unit u_execute_unit (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .oper_i       (id_oper),
        .reg1_i       (id_reg1),
        .reg2_i       (id_reg2),
        .wreg_write_i (id_wreg_write),
        .wreg_addr_i  (id_wreg_addr),
        .oper_o       (ex_oper),
        .result_o     (ex_result),
        .store_data_o (ex_store_data),
        .wreg_write_o (ex_wreg_write),
        .wreg_addr_o  (ex_wreg_addr),
        .wreg_data_o  (ex_fwd_data),
        .is_load_o    (ex_is_load)
    );

    mem_access u_mem_access (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .oper_i          (ex_oper),
        .result_i        (ex_result),
        .store_data_i    (ex_store_data),
        .wreg_write_i    (ex_wreg_write),
        .wreg_addr_i     (ex_wreg_addr),
        .dmem            (dmem_if.master),
        .wb_write_o      (wb_write),
        .wb_addr_o       (wb_addr),
        .wb_data_o       (wb_data),
        .mem_wreg_data_o (mem_fwd_data)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .imem        (imem_if.slave),
        .dmem        (dmem_if.slave),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

//--- dv/cpu_core_asserts.sv
`timescale 1ns/1ps

module cpu_core_asserts (
    input logic clk_i,
    input logic arst_n_i,
    input logic imem_gnt_i,
    input logic dmem_req_i,
    input logic dmem_gnt_i,
    input logic mem_req_i,
    input logic mem_we_i
);

    // one owner of the port per cycle
    grant_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(imem_gnt_i && dmem_gnt_i))
        else $error("fetch and data granted in the same cycle");

    // data side has fixed priority
    data_always_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dmem_req_i |-> dmem_gnt_i)
        else $error("data request left without a grant");

    write_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_we_i |-> mem_req_i)
        else $error("write strobe without a memory request");

endmodule

bind mem_arbiter cpu_core_asserts u_cpu_core_asserts (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .imem_gnt_i (imem.gnt),
    .dmem_req_i (dmem.req),
    .dmem_gnt_i (dmem.gnt),
    .mem_req_i  (mem_req_o),
    .mem_we_i   (mem_we_o)
);

//--- dv/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS    = 6;
    localparam int PROG_LEN     = 12;
    localparam int MEM_WORDS    = 256;

    // primary opcodes
    localparam int ADDIU_OPC = 'h09;
    localparam int ORI_OPC   = 'h0d;
    localparam int LUI_OPC   = 'h0f;
    localparam int LW_OPC    = 'h23;
    localparam int SW_OPC    = 'h2b;
    localparam int BEQ_OPC   = 'h04;
    localparam int BNE_OPC   = 'h05;

    // SPECIAL function codes
    localparam int ADDU_FN = 'h21;
    localparam int SUBU_FN = 'h23;
    localparam int AND_FN  = 'h24;
    localparam int OR_FN   = 'h25;
    localparam int SLT_FN  = 'h2a;

    logic        clk;
    logic        arst_n;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    logic [31:0] mem      [MEM_WORDS];
    logic [31:0] load_img [MEM_WORDS];
    logic        mem_load;

    string       test_name   [NUM_TESTS];
    logic [31:0] test_prog   [NUM_TESTS][PROG_LEN];
    int          test_cycles [NUM_TESTS];
    logic [31:0] check_addr  [NUM_TESTS];
    logic [31:0] expect_word [NUM_TESTS];
    int          cur_test;
    int          cur_pos;

    int pass_count;
    int fail_count;
    int watchdog_cycles = 0;

    cpu_core_top u_cpu_core_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model, combinational read, write at the edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // no valid read data without a request
    assign mem_rdata = mem_req ? mem[mem_addr[9:2]] : 32'hxxxx_xxxx;

    always @(posedge clk) begin
        if (mem_load) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a] <= load_img[a];
            end
        end else if (mem_req && mem_we) begin
            mem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    // rt is the destination, or the source of a store
    function automatic logic [31:0] itype_word(input int op, input int rt, input int rs,
                                               input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] rtype_word(input int funct, input int rd, input int rs,
                                               input int rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, funct[5:0]};
    endfunction

    task automatic begin_test(input int idx, input string name, input int cycles,
                              input logic [31:0] addr, input logic [31:0] word);
        test_name[idx]   = name;
        test_cycles[idx] = cycles;
        check_addr[idx]  = addr;
        expect_word[idx] = word;
        for (int p = 0; p < PROG_LEN; p++) begin
            test_prog[idx][p] = 32'h0000_0000;
        end
        cur_test = idx;
        cur_pos  = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        test_prog[cur_test][cur_pos] = word;
        cur_pos++;
    endtask

    // branch to itself, nop in the delay slot
    task automatic halt_loop();
        emit(itype_word(BEQ_OPC, 0, 0, -1));
        emit(32'h0000_0000);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        // 5, 12, 7, slt 1, 0xabcd0ff6 & 12 = 4, 4 | 1 = 5, plus 0xabcd0ff6
        begin_test(0, "alu_forwarding", 40, 32'h100, 32'habcd_0ffb);
        emit(itype_word(ADDIU_OPC, 1, 0, 5));
        emit(itype_word(ADDIU_OPC, 2, 1, 7));
        emit(rtype_word(SUBU_FN, 3, 2, 1));
        emit(rtype_word(SLT_FN, 4, 3, 2));
        emit(itype_word(LUI_OPC, 5, 0, 'habcd));
        emit(itype_word(ORI_OPC, 6, 5, 'h0ff6));
        emit(rtype_word(AND_FN, 7, 6, 2));
        emit(rtype_word(OR_FN, 8, 7, 4));
        emit(rtype_word(ADDU_FN, 9, 8, 6));
        emit(itype_word(SW_OPC, 9, 0, 'h100));
        halt_loop();

        // 0x55 + 0x10 = 0x65, then 0x65 + 0x55
        begin_test(1, "load_use", 36, 32'h108, 32'h0000_00ba);
        emit(itype_word(ADDIU_OPC, 1, 0, 'h55));
        emit(itype_word(SW_OPC, 1, 0, 'h104));
        emit(itype_word(LW_OPC, 2, 0, 'h104));
        emit(itype_word(ADDIU_OPC, 3, 2, 'h10));
        emit(rtype_word(ADDU_FN, 4, 3, 2));
        emit(itype_word(SW_OPC, 4, 0, 'h108));
        halt_loop();

        // delay slot sets 0x10, skipped word would add 0x20, target adds 1
        begin_test(2, "taken_beq", 32, 32'h10c, 32'h0000_0011);
        emit(itype_word(ADDIU_OPC, 1, 0, 1));
        emit(itype_word(ADDIU_OPC, 2, 0, 1));
        emit(itype_word(BEQ_OPC, 2, 1, 2));
        emit(itype_word(ORI_OPC, 3, 0, 'h10));
        emit(itype_word(ORI_OPC, 4, 0, 'h20));
        emit(rtype_word(OR_FN, 5, 3, 4));
        emit(itype_word(ORI_OPC, 5, 5, 1));
        emit(itype_word(SW_OPC, 5, 0, 'h10c));
        halt_loop();

        // fall through gives 0x100 | 0x200 plus 1, a taken branch only 1
        begin_test(3, "not_taken_bne", 32, 32'h110, 32'h0000_0301);
        emit(itype_word(ADDIU_OPC, 1, 0, 3));
        emit(itype_word(ADDIU_OPC, 2, 0, 3));
        emit(itype_word(BNE_OPC, 2, 1, 3));
        emit(itype_word(ORI_OPC, 3, 0, 'h100));
        emit(itype_word(ORI_OPC, 4, 0, 'h200));
        emit(rtype_word(OR_FN, 5, 3, 4));
        emit(itype_word(ADDIU_OPC, 5, 5, 1));
        emit(itype_word(SW_OPC, 5, 0, 'h110));
        halt_loop();

        begin_test(4, "r0_reads_zero", 32, 32'h114, 32'h0000_0040);
        emit(itype_word(ADDIU_OPC, 0, 0, 'h77));
        emit(itype_word(ORI_OPC, 0, 0, 'h1234));
        emit(itype_word(ADDIU_OPC, 1, 0, 'h40));
        emit(32'h0000_0000);
        emit(32'h0000_0000);
        emit(rtype_word(ADDU_FN, 2, 0, 1));
        emit(itype_word(SW_OPC, 2, 0, 'h114));
        halt_loop();

        // 0x22 - 0x11 only if each store landed at its own word
        begin_test(5, "shared_port", 44, 32'h128, 32'h0000_0011);
        emit(itype_word(ADDIU_OPC, 1, 0, 'h11));
        emit(itype_word(ADDIU_OPC, 2, 1, 'h11));
        emit(itype_word(SW_OPC, 1, 0, 'h120));
        emit(itype_word(SW_OPC, 2, 0, 'h124));
        emit(itype_word(LW_OPC, 3, 0, 'h120));
        emit(itype_word(LW_OPC, 4, 0, 'h124));
        emit(rtype_word(SUBU_FN, 5, 4, 3));
        emit(itype_word(SW_OPC, 5, 0, 'h128));
        halt_loop();
    endtask

    task automatic run_test(input int idx);
        logic [31:0] got;
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (a < PROG_LEN) begin
                load_img[a] = test_prog[idx][a];
            end else begin
                load_img[a] = 32'h0000_0000;
            end
        end
        // image goes in while the core sits in reset
        @(posedge clk);
        arst_n   <= 1'b0;
        mem_load <= 1'b1;
        @(posedge clk);
        mem_load <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        arst_n <= 1'b1;
        repeat (test_cycles[idx]) @(posedge clk);
        @(negedge clk);
        got = mem[check_addr[idx][9:2]];
        if (got !== expect_word[idx]) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h",
                     test_name[idx], expect_word[idx], got);
            fail_count++;
        end else begin
            $display("pass %s: mem[0x%03h] = 0x%08h", test_name[idx], check_addr[idx], got);
            pass_count++;
        end
    endtask

    initial begin
        int total;
        arst_n     = 1'b0;
        mem_load   = 1'b0;
        pass_count = 0;
        fail_count = 0;
        total      = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += test_cycles[t] + RESET_CYCLES + 2;
        end
        // twice the expected length
        watchdog_cycles = total * 2;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d run, %0d passed, %0d failed", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("watchdog expired, the run did not finish within %0d ns",
                 watchdog_cycles * CLK_PERIOD);
        $display("tests failed");
        $finish;
    end

endmodule

//--- tb.f
hw/cpu_pkg.sv
hw/mem_port_if.sv
hw/fetch_unit.sv
hw/id_stage.sv
hw/regfile.sv
hw/execute_unit.sv
hw/mem_access.sv
hw/mem_arbiter.sv
hw/cpu_core_top.sv
dv/cpu_core_asserts.sv
dv/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_cpu_core -f tb.f \
    --Mdir obj_dir -o vtb_cpu_core

out=$(./obj_dir/vtb_cpu_core 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed"
